// ==== source/rv_ex_pkg.sv ====
`default_nettype none

package rv_ex_pkg;

    // Width of every integer register and operand.
    localparam int XLEN = 32;

    // Number of architectural registers and the width of their index.
    localparam int REG_NUM = 32;
    localparam int REG_ADDR_W = 5;

    typedef logic [XLEN-1:0] reg_data_t;       // One register or operand word.
    typedef logic [REG_ADDR_W-1:0] reg_addr_t; // Register index, x0 to x31.

    // ALU operation selector. The issuer delivers it already decoded.
    typedef enum logic [3:0] {
        SEL_OR    = 4'd0,
        SEL_AND   = 4'd1,
        SEL_XOR   = 4'd2,
        SEL_ADD   = 4'd3,
        SEL_SLT   = 4'd4,  // Signed set-less-than.
        SEL_SLTU  = 4'd5,  // Unsigned set-less-than.
        SEL_SLL   = 4'd6,
        SEL_SRL   = 4'd7,
        SEL_SRA   = 4'd8,  // Arithmetic right shift.
        SEL_LUI   = 4'd9,  // Result is the upper immediate as given.
        SEL_AUIPC = 4'd10  // Result is pc plus the upper immediate.
    } alu_sel_t;

endpackage

`default_nettype wire

// ==== source/ex_req_if.sv ====
`timescale 1ns/100ps
`default_nettype none

// One instruction with its operands resolved, as it leaves operand fetch.
interface ex_req_if;

    logic                 valid;  // The register holds a live instruction.
    rv_ex_pkg::alu_sel_t  sel;    // ALU operation.
    rv_ex_pkg::reg_data_t opr1;   // Forwarded rs1, or pc for AUIPC.
    rv_ex_pkg::reg_data_t opr2;   // Forwarded rs2, or the immediate.
    rv_ex_pkg::reg_addr_t rd;     // Destination register.
    logic                 wreg;   // Instruction writes rd.

    // Operand fetch drives the request.
    modport fetch (
        output valid, sel, opr1, opr2, rd, wreg
    );

    // Execute consumes it.
    modport ex (
        input valid, sel, opr1, opr2, rd, wreg
    );

endinterface

`default_nettype wire

// ==== source/wb_if.sv ====
`timescale 1ns/100ps
`default_nettype none

// Writeback stage record. It is forwarded, written to the register file and
// streamed out as the result.
interface wb_if;

    logic                 valid;  // Writeback register holds a result.
    logic                 wreg;   // Result goes to rd.
    rv_ex_pkg::reg_addr_t rd;
    rv_ex_pkg::reg_data_t data;
    logic                 send;   // The record leaves this cycle.

    modport ex    (output valid, wreg, rd, data);
    modport fetch (input valid, wreg, rd, data);        // Second forwarding source.
    modport rf    (input send, wreg, rd, data);         // Register write on send.
    modport ctrl  (input valid, output send);
    modport top   (input send, rd, wreg, data);         // Result stream output.

endinterface

`default_nettype wire

// ==== source/inst_queue.sv ====
`timescale 1ns/100ps
`default_nettype none

module inst_queue #(
    parameter int QUEUE_DEPTH = 4
) (
    input  wire                   clk_i,
    input  wire                   rst_n_i,
    input  wire                   push_i,
    input  rv_ex_pkg::alu_sel_t   sel_i,
    input  rv_ex_pkg::reg_addr_t  rs1_i,
    input  rv_ex_pkg::reg_addr_t  rs2_i,
    input  rv_ex_pkg::reg_data_t  imm_i,
    input  wire                   use_imm_i,
    input  rv_ex_pkg::reg_data_t  pc_i,
    input  rv_ex_pkg::reg_addr_t  rd_i,
    input  wire                   wreg_i,
    input  wire                   pop_i,
    output rv_ex_pkg::alu_sel_t   head_sel_o,
    output rv_ex_pkg::reg_addr_t  head_rs1_o,
    output rv_ex_pkg::reg_addr_t  head_rs2_o,
    output rv_ex_pkg::reg_data_t  head_imm_o,
    output logic                  head_use_imm_o,
    output rv_ex_pkg::reg_data_t  head_pc_o,
    output rv_ex_pkg::reg_addr_t  head_rd_o,
    output logic                  head_wreg_o,
    output logic                  head_valid_o
);

    localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    // One storage array per field. The issuer never pushes into a full queue
    // since it holds exactly QUEUE_DEPTH credits.
    rv_ex_pkg::alu_sel_t  sel_q     [QUEUE_DEPTH];
    rv_ex_pkg::reg_addr_t rs1_q     [QUEUE_DEPTH];
    rv_ex_pkg::reg_addr_t rs2_q     [QUEUE_DEPTH];
    rv_ex_pkg::reg_data_t imm_q     [QUEUE_DEPTH];
    logic                 use_imm_q [QUEUE_DEPTH];
    rv_ex_pkg::reg_data_t pc_q      [QUEUE_DEPTH];
    rv_ex_pkg::reg_addr_t rd_q      [QUEUE_DEPTH];
    logic                 wreg_q    [QUEUE_DEPTH];

    logic [PTR_W-1:0] wr_ptr;  // Next free slot.
    logic [PTR_W-1:0] rd_ptr;  // Oldest entry.
    logic [CNT_W-1:0] count;   // Occupancy.

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr <= (wr_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop_i) begin
                rd_ptr <= (rd_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push_i, pop_i})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // Both or neither leave it as is.
            endcase
        end
    end

    // Entry storage. A push writes every field at the write pointer.
    always_ff @(posedge clk_i) begin
        if (push_i) begin
            sel_q[wr_ptr]     <= sel_i;
            rs1_q[wr_ptr]     <= rs1_i;
            rs2_q[wr_ptr]     <= rs2_i;
            imm_q[wr_ptr]     <= imm_i;
            use_imm_q[wr_ptr] <= use_imm_i;
            pc_q[wr_ptr]      <= pc_i;
            rd_q[wr_ptr]      <= rd_i;
            wreg_q[wr_ptr]    <= wreg_i;
        end
    end

    assign head_sel_o     = sel_q[rd_ptr];
    assign head_rs1_o     = rs1_q[rd_ptr];
    assign head_rs2_o     = rs2_q[rd_ptr];
    assign head_imm_o     = imm_q[rd_ptr];
    assign head_use_imm_o = use_imm_q[rd_ptr];
    assign head_pc_o      = pc_q[rd_ptr];
    assign head_rd_o      = rd_q[rd_ptr];
    assign head_wreg_o    = wreg_q[rd_ptr];
    assign head_valid_o   = (count != '0);  // Head is meaningful only when not empty.

endmodule

`default_nettype wire

// ==== source/regfile.sv ====
`timescale 1ns/100ps
`default_nettype none

module regfile (
    input  wire                   clk_i,
    input  wire                   rst_n_i,
    input  rv_ex_pkg::reg_addr_t  raddr1_i,
    input  rv_ex_pkg::reg_addr_t  raddr2_i,
    output rv_ex_pkg::reg_data_t  rdata1_o,
    output rv_ex_pkg::reg_data_t  rdata2_o,
    wb_if.rf                      wb
);

    rv_ex_pkg::reg_data_t regs [rv_ex_pkg::REG_NUM];

    // Architectural state starts at zero.
    // A result is committed on the edge that ends its send cycle.
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < rv_ex_pkg::REG_NUM; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.send && wb.wreg && (wb.rd != '0)) begin
            regs[wb.rd] <= wb.data;  // x0 is never written.
        end
    end

    // Asynchronous reads. x0 is forced to zero here as well.
    assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];
    assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];

endmodule

`default_nettype wire

// ==== source/operand_fetch.sv ====
`timescale 1ns/100ps
`default_nettype none

module operand_fetch (
    input  wire                   clk_i,
    input  wire                   rst_n_i,
    input  wire                   hold_i,
    input  wire                   pop_i,
    input  rv_ex_pkg::alu_sel_t   head_sel_i,
    input  rv_ex_pkg::reg_addr_t  head_rs1_i,
    input  rv_ex_pkg::reg_addr_t  head_rs2_i,
    input  rv_ex_pkg::reg_data_t  head_imm_i,
    input  wire                   head_use_imm_i,
    input  rv_ex_pkg::reg_data_t  head_pc_i,
    input  rv_ex_pkg::reg_addr_t  head_rd_i,
    input  wire                   head_wreg_i,
    input  wire                   head_valid_i,
    output rv_ex_pkg::reg_addr_t  raddr1_o,
    output rv_ex_pkg::reg_addr_t  raddr2_o,
    input  rv_ex_pkg::reg_data_t  rdata1_i,
    input  rv_ex_pkg::reg_data_t  rdata2_i,
    input  wire                   fwd_we_i,
    input  rv_ex_pkg::reg_addr_t  fwd_rd_i,
    input  rv_ex_pkg::reg_data_t  fwd_data_i,
    wb_if.fetch                   wb,
    ex_req_if.fetch               req
);

    logic                 wb_we;   // Writeback stage holds a register result.
    logic                 ex_hit1, ex_hit2;
    logic                 wb_hit1, wb_hit2;
    rv_ex_pkg::reg_data_t src1, src2;

    // The queue head addresses the register file directly.
    assign raddr1_o = head_rs1_i;
    assign raddr2_o = head_rs2_i;

    assign wb_we = wb.valid && wb.wreg;

    // A match on x0 never counts, so x0 always resolves to zero.
    assign ex_hit1 = fwd_we_i && (fwd_rd_i == head_rs1_i) && (head_rs1_i != '0);
    assign ex_hit2 = fwd_we_i && (fwd_rd_i == head_rs2_i) && (head_rs2_i != '0);
    assign wb_hit1 = wb_we && (wb.rd == head_rs1_i) && (head_rs1_i != '0);
    assign wb_hit2 = wb_we && (wb.rd == head_rs2_i) && (head_rs2_i != '0);

    // The execute stage is younger than writeback and wins.
    assign src1 = ex_hit1 ? fwd_data_i : (wb_hit1 ? wb.data : rdata1_i);
    assign src2 = ex_hit2 ? fwd_data_i : (wb_hit2 ? wb.data : rdata2_i);

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            req.valid <= 1'b0;
            req.wreg  <= 1'b0;
        end else if (!hold_i) begin
            req.valid <= pop_i && head_valid_i;  // A bubble when nothing is popped.
            req.wreg  <= pop_i && head_wreg_i;
        end
    end

    // Operands are captured only when the head is taken. A pop never comes
    // with hold, so a held register keeps its old contents.
    always_ff @(posedge clk_i) begin
        if (pop_i) begin
            req.sel  <= head_sel_i;
            req.opr1 <= (head_sel_i == rv_ex_pkg::SEL_AUIPC) ? head_pc_i : src1;
            req.opr2 <= head_use_imm_i ? head_imm_i : src2;
            req.rd   <= head_rd_i;
        end
    end

endmodule

`default_nettype wire

// ==== source/ex.sv ====
`timescale 1ns/100ps
`default_nettype none

module ex (
    input  wire                   clk_i,
    input  wire                   rst_n_i,
    input  wire                   hold_i,
    ex_req_if.ex                  req,
    output logic                  fwd_we_o,
    output rv_ex_pkg::reg_addr_t  fwd_rd_o,
    output rv_ex_pkg::reg_data_t  fwd_data_o,
    wb_if.ex                      wb
);

    rv_ex_pkg::reg_data_t logicout;  // ALU result for the current request.
    logic [4:0]           shamt;

    assign shamt = req.opr2[4:0];  // Only the low five bits shift.

    always_comb begin
        case (req.sel)
            rv_ex_pkg::SEL_OR: begin
                logicout = req.opr1 | req.opr2;
            end
            rv_ex_pkg::SEL_AND: begin
                logicout = req.opr1 & req.opr2;
            end
            rv_ex_pkg::SEL_XOR: begin
                logicout = req.opr1 ^ req.opr2;
            end
            rv_ex_pkg::SEL_ADD: begin
                logicout = req.opr1 + req.opr2;
            end
            rv_ex_pkg::SEL_SLT: begin
                // Result is a single flag bit, zero extended.
                logicout = ($signed(req.opr1) < $signed(req.opr2)) ?
                           rv_ex_pkg::reg_data_t'(1) : '0;
            end
            rv_ex_pkg::SEL_SLTU: begin
                logicout = (req.opr1 < req.opr2) ? rv_ex_pkg::reg_data_t'(1) : '0;
            end
            rv_ex_pkg::SEL_SLL: begin
                logicout = req.opr1 << shamt;
            end
            rv_ex_pkg::SEL_SRL: begin
                logicout = req.opr1 >> shamt;  // Fills with zeros.
            end
            rv_ex_pkg::SEL_SRA: begin
                logicout = rv_ex_pkg::reg_data_t'($signed(req.opr1) >>> shamt);
            end
            rv_ex_pkg::SEL_LUI: begin
                logicout = req.opr2;  // The immediate already sits in the upper bits.
            end
            rv_ex_pkg::SEL_AUIPC: begin
                logicout = req.opr1 + req.opr2;  // opr1 carries the pc here.
            end
            default: begin
                logicout = '0;
            end
        endcase
    end

    // Execute-stage forward straight from the ALU.
    assign fwd_we_o   = req.valid && req.wreg;
    assign fwd_rd_o   = req.rd;
    assign fwd_data_o = logicout;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wb.valid <= 1'b0;
            wb.wreg  <= 1'b0;
        end else if (!hold_i) begin
            wb.valid <= req.valid;  // An empty request empties the stage.
            wb.wreg  <= req.wreg;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!hold_i) begin
            wb.rd   <= req.rd;
            wb.data <= logicout;
        end
    end

endmodule

`default_nettype wire

// ==== source/pipe_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none

module pipe_ctrl #(
    parameter int CREDIT_MAX = 4
) (
    input  wire   clk_i,
    input  wire   rst_n_i,
    input  wire   head_valid_i,
    input  wire   res_credit_i,
    wb_if.ctrl    wb,
    output logic  hold_o,
    output logic  pop_o,
    output logic  issue_credit_o
);

    localparam int CNT_W = $clog2(CREDIT_MAX + 1);

    logic [CNT_W-1:0] credits;      // Free slots in the consumer.
    logic             has_credit;

    assign has_credit = (credits != '0);

    // A valid result either leaves now or stalls the whole pipe.
    assign wb.send = wb.valid && has_credit;
    assign hold_o  = wb.valid && !has_credit;

    // Take the queue head whenever the pipe moves.
    assign pop_o = head_valid_i && !hold_o;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            credits <= CNT_W'(CREDIT_MAX);
        end else begin
            // A returned credit may coincide with a send.
            case ({wb.send, res_credit_i})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    // Each popped entry frees one slot, so one credit goes back to the issuer.
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            issue_credit_o <= 1'b0;
        end else begin
            issue_credit_o <= pop_o;
        end
    end

endmodule

`default_nettype wire

// ==== source/rv_ex_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module rv_ex_top #(
    parameter int QUEUE_DEPTH = 4,  // Also the issuer's starting credit count.
    parameter int CREDIT_MAX  = 4   // Size of the consumer's result buffer.
) (
    input  wire                   clk_i,
    input  wire                   rst_n_i,
    input  wire                   issue_valid_i,
    input  rv_ex_pkg::alu_sel_t   issue_sel_i,
    input  rv_ex_pkg::reg_addr_t  issue_rs1_i,
    input  rv_ex_pkg::reg_addr_t  issue_rs2_i,
    input  rv_ex_pkg::reg_data_t  issue_imm_i,
    input  wire                   issue_use_imm_i,
    input  rv_ex_pkg::reg_data_t  issue_pc_i,
    input  rv_ex_pkg::reg_addr_t  issue_rd_i,
    input  wire                   issue_wreg_i,
    output logic                  issue_credit_o,
    output logic                  res_valid_o,
    output rv_ex_pkg::reg_addr_t  res_rd_o,
    output logic                  res_wreg_o,
    output rv_ex_pkg::reg_data_t  res_data_o,
    input  wire                   res_credit_i
);

    rv_ex_pkg::alu_sel_t  head_sel;
    rv_ex_pkg::reg_addr_t head_rs1, head_rs2, head_rd;
    rv_ex_pkg::reg_data_t head_imm, head_pc;
    logic                 head_use_imm, head_wreg, head_valid;
    rv_ex_pkg::reg_addr_t raddr1, raddr2;
    rv_ex_pkg::reg_data_t rdata1, rdata2;
    logic                 fwd_we;
    rv_ex_pkg::reg_addr_t fwd_rd;
    rv_ex_pkg::reg_data_t fwd_data;
    logic                 hold, pop;

    ex_req_if req_bus ();
    wb_if     wb_bus ();

    inst_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) inst_queue_i (
        .clk_i(clk_i), .rst_n_i(rst_n_i), .push_i(issue_valid_i),
        .sel_i(issue_sel_i), .rs1_i(issue_rs1_i), .rs2_i(issue_rs2_i),
        .imm_i(issue_imm_i), .use_imm_i(issue_use_imm_i), .pc_i(issue_pc_i),
        .rd_i(issue_rd_i), .wreg_i(issue_wreg_i), .pop_i(pop),
        .head_sel_o(head_sel), .head_rs1_o(head_rs1), .head_rs2_o(head_rs2),
        .head_imm_o(head_imm), .head_use_imm_o(head_use_imm), .head_pc_o(head_pc),
        .head_rd_o(head_rd), .head_wreg_o(head_wreg), .head_valid_o(head_valid)
    );

    regfile regfile_i (
        .clk_i(clk_i), .rst_n_i(rst_n_i), .raddr1_i(raddr1), .raddr2_i(raddr2),
        .rdata1_o(rdata1), .rdata2_o(rdata2), .wb(wb_bus.rf)
    );

    operand_fetch operand_fetch_i (
        .clk_i(clk_i), .rst_n_i(rst_n_i), .hold_i(hold), .pop_i(pop),
        .head_sel_i(head_sel), .head_rs1_i(head_rs1), .head_rs2_i(head_rs2),
        .head_imm_i(head_imm), .head_use_imm_i(head_use_imm), .head_pc_i(head_pc),
        .head_rd_i(head_rd), .head_wreg_i(head_wreg), .head_valid_i(head_valid),
        .raddr1_o(raddr1), .raddr2_o(raddr2), .rdata1_i(rdata1), .rdata2_i(rdata2),
        .fwd_we_i(fwd_we), .fwd_rd_i(fwd_rd), .fwd_data_i(fwd_data),
        .wb(wb_bus.fetch), .req(req_bus.fetch)
    );

    ex ex_i (
        .clk_i(clk_i), .rst_n_i(rst_n_i), .hold_i(hold), .req(req_bus.ex),
        .fwd_we_o(fwd_we), .fwd_rd_o(fwd_rd), .fwd_data_o(fwd_data), .wb(wb_bus.ex)
    );

    pipe_ctrl #(.CREDIT_MAX(CREDIT_MAX)) pipe_ctrl_i (
        .clk_i(clk_i), .rst_n_i(rst_n_i), .head_valid_i(head_valid),
        .res_credit_i(res_credit_i), .wb(wb_bus.ctrl), .hold_o(hold), .pop_o(pop),
        .issue_credit_o(issue_credit_o)
    );

    // The result record is the writeback register, valid while it is sent.
    assign res_valid_o = wb_bus.send;
    assign res_rd_o    = wb_bus.rd;
    assign res_wreg_o  = wb_bus.wreg;
    assign res_data_o  = wb_bus.data;

endmodule

`default_nettype wire

// ==== tb/tb_rv_ex_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_rv_ex_top;

    localparam int QUEUE_DEPTH = 4;
    localparam int CREDIT_MAX  = 4;
    localparam int N_INSTR     = 300;
    localparam int CYCLE_LIMIT = 200 * N_INSTR;  // Generous bound for the slowest consumer.
    localparam int ISS = 0;  // LFSR used by the issuer.
    localparam int CON = 1;  // LFSR used by the consumer.

    logic                 clk_i, rst_n_i;
    logic                 issue_valid_i, issue_use_imm_i, issue_wreg_i;
    rv_ex_pkg::alu_sel_t  issue_sel_i;
    rv_ex_pkg::reg_addr_t issue_rs1_i, issue_rs2_i, issue_rd_i;
    rv_ex_pkg::reg_data_t issue_imm_i, issue_pc_i;
    logic                 issue_credit_o, res_valid_o, res_wreg_o, res_credit_i;
    rv_ex_pkg::reg_addr_t res_rd_o;
    rv_ex_pkg::reg_data_t res_data_o;

    rv_ex_pkg::reg_data_t arch [32];    // Architectural registers in issue order.
    logic [37:0]          exp_q [$];    // Expected {wreg, rd, data} per result.
    logic [31:0]          lfsr_st [2];
    int                   n_issued, n_done, n_returned, cycles;
    int                   pending, wait_cnt;  // Consumer buffer fill and return delay.

    rv_ex_top #(.QUEUE_DEPTH(QUEUE_DEPTH), .CREDIT_MAX(CREDIT_MAX)) dut_i (.*);

    always #10 clk_i = ~clk_i;

    // Fibonacci LFSR with taps 32, 22, 2 and 1. One step per bit taken.
    function automatic logic [31:0] draw_bits(input int which, input int n);
        logic [31:0] val;
        logic        fb;
        val = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_st[which][31] ^ lfsr_st[which][21] ^ lfsr_st[which][1] ^
                 lfsr_st[which][0];
            lfsr_st[which] = {lfsr_st[which][30:0], fb};
            val = {val[30:0], fb};
        end
        return val;
    endfunction

    // Reference ALU. It applies the ISA rules to the architectural registers in issue order.
    function automatic void rv_ex_model(input rv_ex_pkg::alu_sel_t sel,
            input rv_ex_pkg::reg_addr_t rs1, input rv_ex_pkg::reg_addr_t rs2,
            input rv_ex_pkg::reg_data_t imm, input logic use_imm,
            input rv_ex_pkg::reg_data_t pc, input rv_ex_pkg::reg_addr_t rd,
            input logic wreg);
        rv_ex_pkg::reg_data_t a, b, r;
        logic [4:0]           sh;
        a  = (sel == rv_ex_pkg::SEL_AUIPC) ? pc : arch[rs1];
        b  = use_imm ? imm : arch[rs2];
        sh = b[4:0];
        case (sel)
            rv_ex_pkg::SEL_OR:    r = a | b;
            rv_ex_pkg::SEL_AND:   r = a & b;
            rv_ex_pkg::SEL_XOR:   r = a ^ b;
            rv_ex_pkg::SEL_ADD:   r = a + b;
            rv_ex_pkg::SEL_SLT:   r = ((a ^ 32'h8000_0000) < (b ^ 32'h8000_0000)) ? 1 : 0;
            rv_ex_pkg::SEL_SLTU:  r = (a < b) ? 1 : 0;
            rv_ex_pkg::SEL_SLL:   r = a << sh;
            rv_ex_pkg::SEL_SRL:   r = a >> sh;
            rv_ex_pkg::SEL_SRA:   r = a[31] ? ~(~a >> sh) : (a >> sh);  // Sign fill.
            rv_ex_pkg::SEL_LUI:   r = b;
            rv_ex_pkg::SEL_AUIPC: r = a + b;
            default:              r = '0;
        endcase
        if (wreg && (rd != 0)) begin
            arch[rd] = r;  // x0 stays zero.
        end
        exp_q.push_back({wreg, rd, r});
    endfunction

    task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERR %0t %s: got %h, expected %h", $time, what, got, exp);
            $display("RESULT: FAIL");
            $fatal(1, "Value mismatch.");
        end
    endtask

    // Drives one instruction for the next rising edge and records its expected result.
    task automatic drive_instr(input int idx);
        rv_ex_pkg::alu_sel_t  sel;
        rv_ex_pkg::reg_addr_t rs1, rs2, rd;
        rv_ex_pkg::reg_data_t imm, pc;
        logic                 use_imm, wreg;
        if (idx < 3) begin
            // Opening reads of x1 to x3 must see the reset value.
            sel = rv_ex_pkg::SEL_OR;
            rs1 = 5'(idx + 1);
            rs2 = 5'(idx + 1);
            imm = '0;
            pc = '0;
            use_imm = 1'b0;
            rd = '0;
            wreg = 1'b1;
        end else begin
            sel = rv_ex_pkg::alu_sel_t'(4'(draw_bits(ISS, 4) % 11));
            rs1 = 5'(draw_bits(ISS, 2));  // x0 to x3 only, so hazards are frequent.
            rs2 = 5'(draw_bits(ISS, 2));
            rd  = 5'(draw_bits(ISS, 2));
            imm = draw_bits(ISS, 32);
            pc  = {30'(draw_bits(ISS, 30)), 2'b00};
            use_imm = 1'(draw_bits(ISS, 1));
            wreg = (draw_bits(ISS, 3) != 0);
            if (sel == rv_ex_pkg::SEL_LUI || sel == rv_ex_pkg::SEL_AUIPC) begin
                imm = {20'(draw_bits(ISS, 20)), 12'h000};  // Upper immediates carry the operand.
                use_imm = 1'b1;
            end
        end
        issue_valid_i = 1'b1;
        issue_sel_i = sel;
        issue_rs1_i = rs1;
        issue_rs2_i = rs2;
        issue_imm_i = imm;
        issue_use_imm_i = use_imm;
        issue_pc_i = pc;
        issue_rd_i = rd;
        issue_wreg_i = wreg;
        rv_ex_model(sel, rs1, rs2, imm, use_imm, pc, rd, wreg);
    endtask

    // Issuer. Holds QUEUE_DEPTH credits and issues only while one is left.
    initial begin
        int credits;
        clk_i = 1'b0;
        rst_n_i = 1'b0;
        issue_valid_i = 1'b0;
        issue_sel_i = rv_ex_pkg::SEL_OR;
        {issue_rs1_i, issue_rs2_i, issue_rd_i} = '0;
        {issue_imm_i, issue_pc_i} = '0;
        {issue_use_imm_i, issue_wreg_i, res_credit_i} = '0;
        lfsr_st[ISS] = 32'd90211;
        lfsr_st[CON] = 32'd90211;
        for (int i = 0; i < 32; i++) begin
            arch[i] = '0;
        end
        {n_issued, n_done, n_returned, cycles, pending, wait_cnt} = '0;
        credits = QUEUE_DEPTH;
        repeat (10) @(posedge clk_i);
        @(negedge clk_i);
        rst_n_i = 1'b1;
        check("res_valid_o after reset", res_valid_o, 0);
        check("issue_credit_o after reset", issue_credit_o, 0);
        while (n_done < N_INSTR) begin
            @(negedge clk_i);
            if (issue_credit_o) begin
                credits++;
                n_returned++;
            end
            issue_valid_i = 1'b0;
            if (n_issued < N_INSTR && credits > 0 && draw_bits(ISS, 2) != 0) begin
                drive_instr(n_issued);
                credits--;
                n_issued++;
            end
        end
        check("issue credits returned", n_returned, N_INSTR);
        $display("RESULT: PASS");
        $finish;
    end

    // Consumer. Buffers up to CREDIT_MAX results and frees them after random pauses.
    always @(negedge clk_i) begin
        res_credit_i = 1'b0;
        if (res_valid_o) begin
            pending++;
            check("results held by consumer within CREDIT_MAX", pending <= CREDIT_MAX, 1);
        end
        if (pending > 0) begin
            if (wait_cnt == 0) begin
                res_credit_i = 1'b1;
                pending--;
                // Gaps are mostly short. Now and then the result stream stalls for long.
                wait_cnt = (draw_bits(CON, 3) == 0) ? draw_bits(CON, 7) : draw_bits(CON, 2);
            end else begin
                wait_cnt--;
            end
        end
    end

    // Comparator. Outputs are stable at the falling edge.
    always @(negedge clk_i) begin
        logic [37:0] exp;
        if (res_valid_o) begin
            if (exp_q.size() == 0) begin
                $display("A result arrived with no instruction outstanding.");
                $display("RESULT: FAIL");
                $fatal(1, "Unexpected result.");
            end
            exp = exp_q.pop_front();
            check("res_rd_o", res_rd_o, exp[36:32]);
            check("res_wreg_o", res_wreg_o, exp[37]);
            check("res_data_o", res_data_o, exp[31:0]);
            n_done++;
        end
    end

    always @(posedge clk_i) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: only %0d of %0d results arrived.", n_done, N_INSTR);
            $display("RESULT: FAIL");
            $fatal(1, "Run did not finish in time.");
        end
    end

endmodule

`default_nettype wire

// ==== rv_ex.f ====
source/rv_ex_pkg.sv
source/ex_req_if.sv
source/wb_if.sv
source/inst_queue.sv
source/regfile.sv
source/operand_fetch.sv
source/ex.sv
source/pipe_ctrl.sv
source/rv_ex_top.sv
tb/tb_rv_ex_top.sv

// ==== Bender.yml ====
package:
  name: rv_ex

sources:
  - files:
      - source/rv_ex_pkg.sv
      - source/ex_req_if.sv
      - source/wb_if.sv
      - source/inst_queue.sv
      - source/regfile.sv
      - source/operand_fetch.sv
      - source/ex.sv
      - source/pipe_ctrl.sv
      - source/rv_ex_top.sv
  - target: test
    files:
      - tb/tb_rv_ex_top.sv
